/* flowCtrlPkg.sv */
package flowCtrlPkg;

  // destination field width, taken from the top bits of every word
  localparam int DEST_W = 2;

  // one channel per destination code
  localparam int NUM_CH = 1 << DEST_W;

  // per-channel vector for strobes, masks, errors and credits
  typedef logic [NUM_CH-1:0] chMask_t;

  // flow-control FSM states
  typedef enum logic [2:0] {
    stReset,
    stInit,
    stIdle,
    stActive,
    stPause,
    stContinue,
    stError
  } fsmState_e;

endpackage

/* chanStatusIf.sv */
`timescale 1ns/1ps

interface chanStatusIf;

  // occupancy flags of the output FIFOs
  flowCtrlPkg::chMask_t empty;
  flowCtrlPkg::chMask_t full;
  flowCtrlPkg::chMask_t almostFull;
  flowCtrlPkg::chMask_t almostEmpty;

  // destinations held back by the flow-control FSM
  flowCtrlPkg::chMask_t paused;

  // FIFO side drives the flags
  modport fifo (
    output empty, full, almostFull, almostEmpty
  );

  // FSM watches thresholds and owns the paused mask
  modport fsm (
    input  empty, full, almostFull, almostEmpty,
    output paused
  );

  // arbiter only needs to know where it may not write
  modport arb (
    input full, paused
  );

endinterface

/* syncFifo.sv */
`timescale 1ns/1ps

module syncFifo #(
  parameter int WORD_W = 8,
  parameter int DEPTH  = 8,
  parameter int CNT_W  = 4
) (
  input  logic              CLK,
  input  logic              arstN,
  input  logic              push,
  input  logic [WORD_W-1:0] pushData,
  input  logic              pop,
  output logic [WORD_W-1:0] popData,
  input  logic [CNT_W-1:0]  lowThresh,
  input  logic [CNT_W-1:0]  highThresh,
  output logic              empty,
  output logic              full,
  output logic              almostFull,
  output logic              almostEmpty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WORD_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wrPtr;
  logic [PTR_W-1:0]  rdPtr;
  logic [CNT_W-1:0]  count;
  logic              doPush;
  logic              doPop;

  // requests beyond the current fill are dropped
  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head word is visible without a pop
  assign popData = mem[rdPtr];

  assign empty       = (count == '0);
  assign full        = (count == CNT_W'(DEPTH));
  assign almostFull  = (count >= highThresh);
  assign almostEmpty = (count <= lowThresh);

endmodule

/* flowCtrlFsm.sv */
`timescale 1ns/1ps

module flowCtrlFsm #(
  parameter int DEPTH = 8,
  parameter int CNT_W = 4
) (
  input  logic                   CLK,
  input  logic                   arstN,
  input  logic                   init,
  input  flowCtrlPkg::chMask_t   inEmpty,
  chanStatusIf.fsm               outStat,
  input  logic [CNT_W-1:0]       lowThreshIn,
  input  logic [CNT_W-1:0]       highThreshIn,
  output logic [CNT_W-1:0]       lowThresh,
  output logic [CNT_W-1:0]       highThresh,
  output logic                   arbEnable,
  output logic                   initBusy,
  output logic                   idle,
  output flowCtrlPkg::chMask_t   stbPause,
  output flowCtrlPkg::chMask_t   stbContinue,
  output flowCtrlPkg::chMask_t   error,
  output flowCtrlPkg::fsmState_e state
);

  flowCtrlPkg::fsmState_e nextState;
  flowCtrlPkg::chMask_t   afPrev;
  flowCtrlPkg::chMask_t   aePrev;
  flowCtrlPkg::chMask_t   pausedQ;
  flowCtrlPkg::chMask_t   pauseRise;
  flowCtrlPkg::chMask_t   contRise;
  logic                   eventsOn;
  logic                   runNext;

  // threshold events are tracked only once traffic has started
  assign eventsOn = state inside {flowCtrlPkg::stActive, flowCtrlPkg::stPause,
                                  flowCtrlPkg::stContinue};

  assign arbEnable = eventsOn || (state == flowCtrlPkg::stIdle);

  assign runNext = nextState inside {flowCtrlPkg::stIdle, flowCtrlPkg::stActive,
                                     flowCtrlPkg::stPause, flowCtrlPkg::stContinue};

  // a destination is paused at most once until it drains
  assign pauseRise = eventsOn ? (outStat.almostFull & ~afPrev & ~pausedQ) : '0;
  assign contRise  = eventsOn ? (outStat.almostEmpty & ~aePrev & pausedQ) : '0;

  assign outStat.paused = pausedQ;

  always_comb begin
    nextState = state;
    case (state)
      flowCtrlPkg::stReset: begin
        nextState = flowCtrlPkg::stInit;
      end
      flowCtrlPkg::stInit: begin
        if (!init) begin
          nextState = flowCtrlPkg::stIdle;
        end
      end
      flowCtrlPkg::stIdle: begin
        if (|outStat.full) begin
          nextState = flowCtrlPkg::stError;
        end else if (!(&inEmpty)) begin
          nextState = flowCtrlPkg::stActive;
        end
      end
      flowCtrlPkg::stActive, flowCtrlPkg::stPause, flowCtrlPkg::stContinue: begin
        // overflow wins over any strobe
        if (|outStat.full) begin
          nextState = flowCtrlPkg::stError;
        end else if (|pauseRise) begin
          nextState = flowCtrlPkg::stPause;
        end else if (|contRise) begin
          nextState = flowCtrlPkg::stContinue;
        end else begin
          nextState = flowCtrlPkg::stActive;
        end
      end
      flowCtrlPkg::stError: begin
        // only the asynchronous reset gets out of here
        nextState = flowCtrlPkg::stError;
      end
      default: begin
        nextState = flowCtrlPkg::stReset;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state       <= flowCtrlPkg::stReset;
      stbPause    <= '0;
      stbContinue <= '0;
      pausedQ     <= '0;
      error       <= '0;
      afPrev      <= '0;
      aePrev      <= '0;
      initBusy    <= 1'b0;
      idle        <= 1'b0;
      lowThresh   <= '0;
      highThresh  <= CNT_W'(DEPTH);
    end else begin
      state       <= nextState;
      stbPause    <= pauseRise;
      stbContinue <= contRise;
      pausedQ     <= (pausedQ | pauseRise) & ~contRise;
      // sticky until reset
      error       <= error | outStat.full;
      initBusy    <= (nextState == flowCtrlPkg::stInit);
      idle        <= runNext && (&inEmpty);
      if (eventsOn) begin
        afPrev <= outStat.almostFull;
        aePrev <= outStat.almostEmpty;
      end
      if (state == flowCtrlPkg::stInit) begin
        lowThresh <= lowThreshIn;
        // a threshold past the FIFO depth could never trigger
        highThresh <= (highThreshIn > CNT_W'(DEPTH)) ? CNT_W'(DEPTH) : highThreshIn;
      end
    end
  end

endmodule

/* rrArbiter.sv */
`timescale 1ns/1ps

module rrArbiter #(
  parameter int WORD_W = 8
) (
  input  logic                                       CLK,
  input  logic                                       arstN,
  input  logic                                       enable,
  input  flowCtrlPkg::chMask_t                       inEmpty,
  input  logic [flowCtrlPkg::NUM_CH-1:0][WORD_W-1:0] inHead,
  output flowCtrlPkg::chMask_t                       inPop,
  chanStatusIf.arb                                   outStat,
  output flowCtrlPkg::chMask_t                       outPush,
  output logic [WORD_W-1:0]                          outWord
);

  localparam int IDX_W = $clog2(flowCtrlPkg::NUM_CH);

  logic [flowCtrlPkg::NUM_CH-1:0][flowCtrlPkg::DEST_W-1:0] headDest;
  flowCtrlPkg::chMask_t eligible;
  logic [IDX_W-1:0]     lastGrant;
  logic [IDX_W-1:0]     grant;
  logic [IDX_W-1:0]     idx;
  logic                 found;

  // destination decode and blocking check per input head
  always_comb begin
    for (int i = 0; i < flowCtrlPkg::NUM_CH; i++) begin
      headDest[i] = inHead[i][WORD_W-1 -: flowCtrlPkg::DEST_W];
      eligible[i] = enable && !inEmpty[i]
                    && !outStat.paused[headDest[i]] && !outStat.full[headDest[i]];
    end
  end

  // search starts one past the last winner
  always_comb begin
    found = 1'b0;
    grant = lastGrant;
    idx   = lastGrant;
    for (int k = 1; k <= flowCtrlPkg::NUM_CH; k++) begin
      // index wraps naturally, channel count is a power of two
      idx = lastGrant + IDX_W'(k);
      if (!found && eligible[idx]) begin
        found = 1'b1;
        grant = idx;
      end
    end
  end

  // pop and push happen on the same edge
  always_comb begin
    inPop   = '0;
    outPush = '0;
    if (found) begin
      inPop[grant]             = 1'b1;
      outPush[headDest[grant]] = 1'b1;
    end
  end

  assign outWord = inHead[grant];

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      // first search then starts at channel 0
      lastGrant <= IDX_W'(flowCtrlPkg::NUM_CH - 1);
    end else if (found) begin
      lastGrant <= grant;
    end
  end

endmodule

/* vcSwitch.sv */
`timescale 1ns/1ps

module vcSwitch #(
  parameter int WORD_W = 8,
  parameter int DEPTH  = 8,
  parameter int CNT_W  = $clog2(DEPTH + 1)
) (
  input  logic                                       CLK,
  input  logic                                       arstN,
  input  logic                                       init,
  input  logic [CNT_W-1:0]                           lowThreshIn,
  input  logic [CNT_W-1:0]                           highThreshIn,
  input  flowCtrlPkg::chMask_t                       inPush,
  input  logic [flowCtrlPkg::NUM_CH-1:0][WORD_W-1:0] inData,
  output flowCtrlPkg::chMask_t                       creditReturn,
  input  flowCtrlPkg::chMask_t                       outPop,
  output logic [flowCtrlPkg::NUM_CH-1:0][WORD_W-1:0] outData,
  output flowCtrlPkg::chMask_t                       outEmpty,
  output logic                                       idle,
  output logic                                       initBusy,
  output flowCtrlPkg::chMask_t                       stbPause,
  output flowCtrlPkg::chMask_t                       stbContinue,
  output flowCtrlPkg::chMask_t                       error,
  output flowCtrlPkg::fsmState_e                     state
);

  flowCtrlPkg::chMask_t                       inEmpty;
  flowCtrlPkg::chMask_t                       inPop;
  flowCtrlPkg::chMask_t                       outPush;
  logic [flowCtrlPkg::NUM_CH-1:0][WORD_W-1:0] inHead;
  logic [WORD_W-1:0]                          outWord;
  logic [CNT_W-1:0]                           lowThresh;
  logic [CNT_W-1:0]                           highThresh;
  logic                                       arbEnable;

  chanStatusIf outStat ();

  for (genvar ch = 0; ch < flowCtrlPkg::NUM_CH; ch++) begin : gChan
    // input side, one per source, almost flags unused here
    syncFifo #(.WORD_W(WORD_W), .DEPTH(DEPTH), .CNT_W(CNT_W)) inFifo_i (
      .CLK(CLK), .arstN(arstN),
      .push(inPush[ch]), .pushData(inData[ch]),
      .pop(inPop[ch]), .popData(inHead[ch]),
      .lowThresh(lowThresh), .highThresh(highThresh),
      .empty(inEmpty[ch]), .full(),
      .almostFull(), .almostEmpty()
    );

    // output side, one per destination
    syncFifo #(.WORD_W(WORD_W), .DEPTH(DEPTH), .CNT_W(CNT_W)) outFifo_i (
      .CLK(CLK), .arstN(arstN),
      .push(outPush[ch]), .pushData(outWord),
      .pop(outPop[ch]), .popData(outData[ch]),
      .lowThresh(lowThresh), .highThresh(highThresh),
      .empty(outStat.empty[ch]), .full(outStat.full[ch]),
      .almostFull(outStat.almostFull[ch]), .almostEmpty(outStat.almostEmpty[ch])
    );
  end

  assign outEmpty = outStat.empty;

  rrArbiter #(.WORD_W(WORD_W)) rrArbiter_i (
    .CLK(CLK), .arstN(arstN),
    .enable(arbEnable),
    .inEmpty(inEmpty), .inHead(inHead), .inPop(inPop),
    .outStat(outStat.arb),
    .outPush(outPush), .outWord(outWord)
  );

  flowCtrlFsm #(.DEPTH(DEPTH), .CNT_W(CNT_W)) flowCtrlFsm_i (
    .CLK(CLK), .arstN(arstN),
    .init(init), .inEmpty(inEmpty),
    .outStat(outStat.fsm),
    .lowThreshIn(lowThreshIn), .highThreshIn(highThreshIn),
    .lowThresh(lowThresh), .highThresh(highThresh),
    .arbEnable(arbEnable), .initBusy(initBusy), .idle(idle),
    .stbPause(stbPause), .stbContinue(stbContinue),
    .error(error), .state(state)
  );

  // one credit back per input pop, a cycle later
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      creditReturn <= '0;
    end else begin
      creditReturn <= inPop;
    end
  end

endmodule

/* vcSwitch_checker.sv */
`timescale 1ns/1ps

module vcSwitch_checker #(
  parameter int DEPTH = 8
) (
  input logic                   CLK,
  input logic                   arstN,
  input flowCtrlPkg::chMask_t   inPush,
  input flowCtrlPkg::chMask_t   inPop,
  input flowCtrlPkg::chMask_t   creditReturn,
  input flowCtrlPkg::chMask_t   stbPause,
  input flowCtrlPkg::chMask_t   stbContinue,
  input flowCtrlPkg::chMask_t   error,
  input flowCtrlPkg::fsmState_e state
);

  int failCount = 0;
  int inCnt [flowCtrlPkg::NUM_CH];

  // shadow occupancy of the input FIFOs
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < flowCtrlPkg::NUM_CH; i++) begin
        inCnt[i] <= 0;
      end
    end else begin
      for (int i = 0; i < flowCtrlPkg::NUM_CH; i++) begin
        inCnt[i] <= inCnt[i] + int'(inPush[i]) - int'(inPop[i]);
      end
    end
  end

  // strobes last one cycle and never collide
  assert property (@(posedge CLK) disable iff (!arstN)
    (stbPause & $past(stbPause)) == '0)
  else begin
    failCount++;
    $error("pause strobe held longer than one cycle");
  end

  assert property (@(posedge CLK) disable iff (!arstN) (stbPause & stbContinue) == '0)
  else begin
    failCount++;
    $error("pause and continue strobes on the same channel");
  end

  for (genvar ch = 0; ch < flowCtrlPkg::NUM_CH; ch++) begin : gIn
    assert property (@(posedge CLK) disable iff (!arstN) inPush[ch] |-> inCnt[ch] < DEPTH)
    else begin
      failCount++;
      $error("push into a full input FIFO on channel %0d", ch);
    end

    // a credit only comes back for a word that was queued
    assert property (@(posedge CLK) disable iff (!arstN)
      creditReturn[ch] |-> $past(inCnt[ch]) > 0)
    else begin
      failCount++;
      $error("credit returned on channel %0d with its input FIFO empty", ch);
    end
  end

  // error bits only clear through reset
  assert property (@(posedge CLK) disable iff (!arstN) ($past(error) & ~error) == '0)
  else begin
    failCount++;
    $error("sticky error bit cleared without reset");
  end

  assert property (@(posedge CLK) disable iff (!arstN) |error |-> state == flowCtrlPkg::stError)
  else begin
    failCount++;
    $error("error set outside the Error state");
  end

endmodule

/* vcSwitchTb.sv */
`timescale 1ns/1ps

module vcSwitchTb;

  localparam int WORD_W = 8;
  localparam int DEPTH  = 8;
  localparam int CNT_W  = 4;
  localparam int NCH    = flowCtrlPkg::NUM_CH;
  localparam int QLEN   = 32;
  localparam int TMO    = 2000;
  localparam int LO_T   = 2;
  localparam int HI_T   = 5;
  localparam int PDEST  = 2;
  localparam int ODEST  = 1;
  localparam int EDEST  = 3;

  logic                       CLK;
  logic                       arstN;
  logic                       init;
  logic [CNT_W-1:0]           lowThreshIn;
  logic [CNT_W-1:0]           highThreshIn;
  flowCtrlPkg::chMask_t       inPush;
  logic [NCH-1:0][WORD_W-1:0] inData;
  flowCtrlPkg::chMask_t       creditReturn;
  flowCtrlPkg::chMask_t       outPop;
  logic [NCH-1:0][WORD_W-1:0] outData;
  flowCtrlPkg::chMask_t       outEmpty;
  logic                       idle;
  logic                       initBusy;
  flowCtrlPkg::chMask_t       stbPause;
  flowCtrlPkg::chMask_t       stbContinue;
  flowCtrlPkg::chMask_t       error;
  flowCtrlPkg::fsmState_e     state;

  logic [31:0]          lfsr;
  string                testName;
  flowCtrlPkg::chMask_t popMask;
  // one ring buffer per source and destination pair
  logic [WORD_W-1:0]    pairMem [NCH*NCH][QLEN];
  int wrIdx [NCH*NCH];
  int rdIdx [NCH*NCH];
  int credits [NCH];
  int pushed [NCH];
  int returned [NCH];
  int pauseCnt [NCH];
  int contCnt [NCH];
  int delivered [NCH];

  vcSwitch #(.WORD_W(WORD_W), .DEPTH(DEPTH), .CNT_W(CNT_W)) vcSwitch_i (
    .CLK(CLK), .arstN(arstN), .init(init),
    .lowThreshIn(lowThreshIn), .highThreshIn(highThreshIn),
    .inPush(inPush), .inData(inData), .creditReturn(creditReturn),
    .outPop(outPop), .outData(outData), .outEmpty(outEmpty),
    .idle(idle), .initBusy(initBusy), .stbPause(stbPause),
    .stbContinue(stbContinue), .error(error), .state(state)
  );

  bind vcSwitch vcSwitch_checker #(.DEPTH(DEPTH)) checker_i (
    .CLK(CLK), .arstN(arstN), .inPush(inPush), .inPop(inPop),
    .creditReturn(creditReturn), .stbPause(stbPause), .stbContinue(stbContinue),
    .error(error), .state(state)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  // taps 32, 22, 2, 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic cmpWord(input string what, input logic [WORD_W-1:0] exp, act);
    if (act !== exp) begin
      failRun($sformatf("ERR %s %s expected %h actual %h", testName, what, exp, act));
    end
  endtask

  task automatic cmpMask(input string what, input flowCtrlPkg::chMask_t exp, act);
    if (act !== exp) begin
      failRun($sformatf("ERR %s %s expected %b actual %b", testName, what, exp, act));
    end
  endtask

  task automatic cmpState(input string what, input flowCtrlPkg::fsmState_e exp, act);
    if (act !== exp) begin
      failRun($sformatf("ERR %s %s expected %s actual %s", testName, what,
                        exp.name(), act.name()));
    end
  endtask

  task automatic cmpFlag(input string what, input logic exp, act);
    if (act !== exp) begin
      failRun($sformatf("ERR %s %s expected %b actual %b", testName, what, exp, act));
    end
  endtask

  task automatic cmpCount(input string what, input int exp, act);
    if (act != exp) begin
      failRun($sformatf("ERR %s %s expected %0d actual %0d", testName, what, exp, act));
    end
  endtask

  task automatic resetModel();
    for (int p = 0; p < NCH*NCH; p++) begin
      wrIdx[p] = 0;
      rdIdx[p] = 0;
    end
    for (int i = 0; i < NCH; i++) begin
      credits[i] = DEPTH;
      pushed[i] = 0;
      returned[i] = 0;
      pauseCnt[i] = 0;
      contCnt[i] = 0;
      delivered[i] = 0;
    end
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < NCH*NCH; p++) begin
      n += wrIdx[p] - rdIdx[p];
    end
    return n;
  endfunction

  // source sits in bits 5:4 of every word
  task automatic checkOutput(input int dst);
    logic [WORD_W-1:0] word;
    int p;
    word = outData[dst];
    p = int'(word[5:4]) * NCH + dst;
    if (rdIdx[p] == wrIdx[p]) begin
      failRun($sformatf("word %h appeared at destination %0d with none pending", word, dst));
    end
    cmpWord($sformatf("dest %0d", dst), pairMem[p][rdIdx[p] % QLEN], word);
    rdIdx[p]++;
    delivered[dst]++;
  endtask

  // one cycle: sample at the falling edge, then drive
  task automatic stepCycle(input flowCtrlPkg::chMask_t srcMask, input int dest);
    logic [WORD_W-1:0] word;
    logic [1:0] d;
    int p;
    @(negedge CLK);
    for (int i = 0; i < NCH; i++) begin
      if (creditReturn[i]) begin
        credits[i]++;
        returned[i]++;
      end
      pauseCnt[i] += int'(stbPause[i]);
      contCnt[i] += int'(stbContinue[i]);
    end
    outPop = '0;
    for (int i = 0; i < NCH; i++) begin
      if (popMask[i] && !outEmpty[i] && randBits(2) != 0) begin
        checkOutput(i);
        outPop[i] = 1'b1;
      end
    end
    inPush = '0;
    for (int s = 0; s < NCH; s++) begin
      if (srcMask[s] && credits[s] > 0 && randBits(1) == 1) begin
        d = (dest < 0) ? 2'(randBits(2)) : 2'(dest);
        word = {d, 2'(s), 4'(randBits(4))};
        p = s * NCH + int'(d);
        pairMem[p][wrIdx[p] % QLEN] = word;
        wrIdx[p]++;
        inData[s] = word;
        inPush[s] = 1'b1;
        credits[s]--;
        pushed[s]++;
      end
    end
  endtask

  task automatic waitState(input flowCtrlPkg::fsmState_e want);
    int t;
    t = 0;
    while (state != want) begin
      stepCycle('0, -1);
      t++;
      if (t > TMO) begin
        failRun($sformatf("timeout waiting for state %s", want.name()));
      end
    end
  endtask

  // pop every word the model still expects
  task automatic drainAll();
    int t;
    popMask = '1;
    t = 0;
    while (pending() != 0) begin
      stepCycle('0, -1);
      t++;
      if (t > TMO) begin
        failRun("timeout while draining the switch");
      end
    end
    // idle and the last credit land a cycle after the final input pop
    stepCycle('0, -1);
  endtask

  initial begin
    int t;
    int n;
    int base;
    lfsr = 32'h8fe7_f3ff;
    arstN = 1'b0;
    init = 1'b1;
    lowThreshIn = CNT_W'(LO_T);
    highThreshIn = CNT_W'(HI_T);
    inPush = '0;
    inData = '0;
    outPop = '0;
    popMask = '0;
    resetModel();
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    arstN = 1'b1;

    testName = "init";
    waitState(flowCtrlPkg::stInit);
    for (int k = 0; k < 6; k++) begin
      stepCycle('1, -1);
      cmpState("state", flowCtrlPkg::stInit, state);
      cmpFlag("initBusy", 1'b1, initBusy);
      cmpMask("creditReturn", '0, creditReturn);
    end
    init = 1'b0;
    waitState(flowCtrlPkg::stIdle);

    testName = "random";
    popMask = '1;
    repeat (400) stepCycle('1, -1);

    testName = "credits";
    drainAll();
    for (int s = 0; s < NCH; s++) begin
      cmpCount($sformatf("credits of source %0d", s), pushed[s], returned[s]);
    end
    cmpFlag("idle", 1'b1, idle);

    // consumer of PDEST stops, sources 0 to 2 feed it
    testName = "pause";
    popMask[PDEST] = 1'b0;
    for (int i = 0; i < NCH; i++) begin
      pauseCnt[i] = 0;
      contCnt[i] = 0;
    end
    t = 0;
    while (pauseCnt[PDEST] == 0) begin
      stepCycle(4'b0111, PDEST);
      t++;
      if (t > TMO) failRun("timeout waiting for the pause strobe");
    end

    testName = "others";
    base = delivered[ODEST];
    n = pushed[3];
    t = 0;
    while (delivered[ODEST] < base + 4) begin
      stepCycle((pushed[3] < n + 4) ? 4'b1000 : 4'b0000, ODEST);
      t++;
      if (t > TMO) failRun("timeout waiting for traffic past the paused destination");
    end
    cmpCount("continue strobes", 0, contCnt[PDEST]);

    testName = "pause";
    base = delivered[PDEST];
    popMask[PDEST] = 1'b1;
    t = 0;
    while (contCnt[PDEST] == 0) begin
      stepCycle('0, -1);
      t++;
      if (t > TMO) failRun("timeout waiting for the continue strobe");
    end
    n = delivered[PDEST] - base;
    if (n < HI_T - LO_T || n > HI_T + 1) begin
      failRun($sformatf("%0d words retrieved from the paused destination", n));
    end
    cmpCount("pause strobes", 1, pauseCnt[PDEST]);
    drainAll();

    // new thresholds need another pass through Init
    testName = "error";
    @(negedge CLK);
    arstN = 1'b0;
    init = 1'b1;
    highThreshIn = CNT_W'(DEPTH);
    inPush = '0;
    outPop = '0;
    popMask = '0;
    resetModel();
    repeat (8) @(negedge CLK);
    cmpState("state in reset", flowCtrlPkg::stReset, state);
    arstN = 1'b1;
    waitState(flowCtrlPkg::stInit);
    init = 1'b0;
    waitState(flowCtrlPkg::stIdle);
    t = 0;
    while (error == '0) begin
      stepCycle(4'b0011, EDEST);
      t++;
      if (t > TMO) failRun("timeout waiting for the overflow error");
    end
    cmpMask("error", flowCtrlPkg::chMask_t'(1 << EDEST), error);
    cmpState("state", flowCtrlPkg::stError, state);
    popMask[EDEST] = 1'b1;
    repeat (10) begin
      stepCycle('0, -1);
      cmpMask("error held", flowCtrlPkg::chMask_t'(1 << EDEST), error);
      cmpState("state held", flowCtrlPkg::stError, state);
    end
    outPop = '0;
    arstN = 1'b0;
    @(negedge CLK);
    cmpState("state after reset pulse", flowCtrlPkg::stReset, state);
    cmpMask("error after reset pulse", '0, error);
    arstN = 1'b1;
    @(negedge CLK);

    if (vcSwitch_i.checker_i.failCount != 0) begin
      $display("checker reported %0d assertion failures", vcSwitch_i.checker_i.failCount);
      $display("tests failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* build.f */
flowCtrlPkg.sv
chanStatusIf.sv
syncFifo.sv
flowCtrlFsm.sv
rrArbiter.sv
vcSwitch.sv
vcSwitch_checker.sv
vcSwitchTb.sv
